// File: rtl/sdlc_pkg.sv
`default_nettype none

package sdlc_pkg;

    // Bit timing
    localparam int BIT_PERIOD     = 16;   // System clocks per line bit
    localparam int BIT_PHASE_W    = 4;
    localparam int CLK_RISE_PHASE = 8;    // Mid-bit

    // Byte FIFO
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_ADDR_W = 4;

    localparam int STUFF_RUN = 5;         // Ones before a zero is inserted

    typedef logic [7:0]             byte_t;
    typedef logic [2:0]             bit_idx_t;
    typedef logic [15:0]            crc_t;
    typedef logic [3:0]             crc_idx_t;
    typedef logic [BIT_PHASE_W-1:0] bit_phase_t;
    typedef logic [FIFO_ADDR_W-1:0] fifo_ptr_t;

    localparam byte_t FLAG_BYTE  = 8'h7E;
    localparam crc_t  CRC_POLY   = 16'h8408;   // CCITT, bit reversed
    localparam crc_t  CRC_PRESET = 16'hFFFF;

    // Host write, one strobe per byte
    typedef struct packed {
        logic  strobe;
        byte_t data;
    } host_wr_t;

    // Bit offered by the framer to the zero inserter
    typedef struct packed {
        logic value;
        logic stuffable;    // Payload or CRC bit
        logic present;      // Frame in progress
    } line_bit_t;

    typedef enum logic [1:0] {
        CRC_HOLD,
        CRC_INIT,
        CRC_FEED,
        CRC_SHIFT
    } crc_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FLAG_OPEN,
        ST_PAYLOAD,
        ST_CRC,
        ST_FLAG_CLOSE
    } framer_state_e;

endpackage

`default_nettype wire

// File: rtl/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_timer (
    input  logic clk,
    input  logic tx_crc_rst,
    output logic bit_strobe,
    output logic tx_clk
);
    import sdlc_pkg::*;

    bit_phase_t phase;
    bit_phase_t phase_nxt;

    assign phase_nxt = (phase == bit_phase_t'(BIT_PERIOD - 1)) ? '0 : phase + 1'b1;

    // One cycle per bit period, at phase 0
    assign bit_strobe = (phase == '0);

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            phase  <= '0;
            tx_clk <= 1'b0;
        end else begin
            phase  <= phase_nxt;
            // High for the second half of the bit, rising edge mid-bit
            tx_clk <= (phase_nxt >= bit_phase_t'(CLK_RISE_PHASE));
        end
    end

endmodule

`default_nettype wire

// File: rtl/tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tx_fifo (
    input  logic               clk,
    input  logic               tx_crc_rst,
    input  sdlc_pkg::host_wr_t host_wr,
    input  logic               pop,
    output sdlc_pkg::byte_t    rd_data,
    output logic               fifo_empty
);
    import sdlc_pkg::*;

    byte_t                mem [FIFO_DEPTH];
    fifo_ptr_t            wr_ptr;
    fifo_ptr_t            rd_ptr;
    logic [FIFO_ADDR_W:0] count;      // One bit wider to hold FIFO_DEPTH
    logic                 full;
    logic                 push;
    logic                 pull;

    assign full       = (count == FIFO_DEPTH);
    assign fifo_empty = (count == '0);

    assign push = host_wr.strobe & ~full;   // Byte is dropped when full
    assign pull = pop & ~fifo_empty;

    assign rd_data = mem[rd_ptr];   // Head byte

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= host_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/crc16_tx.sv
`timescale 1ns/1ps
`default_nettype none

module crc16_tx (
    input  logic              clk,
    input  logic              tx_crc_rst,
    input  sdlc_pkg::crc_op_e crc_op,
    input  logic              crc_din,
    output logic              crc_dout
);
    import sdlc_pkg::*;

    crc_t crc;
    logic feedback;

    // LSB first, so the register shifts right
    assign feedback = crc[0] ^ crc_din;

    // Next CRC bit on the line, already complemented
    assign crc_dout = ~crc[0];

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            crc <= CRC_PRESET;
        end else begin
            case (crc_op)
                CRC_INIT: begin
                    crc <= CRC_PRESET;
                end
                CRC_FEED: begin
                    crc <= (crc >> 1) ^ (feedback ? CRC_POLY : crc_t'(0));
                end
                CRC_SHIFT: begin
                    // Ones fill, complement of the remaining result bits
                    crc <= {1'b1, crc[$bits(crc_t)-1:1]};
                end
                default: begin
                    crc <= crc;     // Hold
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_framer (
    input  logic                clk,
    input  logic                tx_crc_rst,
    input  logic                bit_strobe,
    input  logic                fifo_empty,
    input  sdlc_pkg::byte_t     rd_data,
    input  logic                zero_ins,
    input  logic                crc_dout,
    output logic                pop,
    output logic                tx_drq,
    output sdlc_pkg::crc_op_e   crc_op,
    output logic                crc_din,
    output sdlc_pkg::line_bit_t tx_bit
);
    import sdlc_pkg::*;

    framer_state_e state;
    byte_t         shreg;       // Payload byte, LSB goes out first
    bit_idx_t      bit_idx;
    crc_idx_t      crc_idx;
    logic          consume;
    logic          last_bit;
    logic          byte_end;
    logic          load_byte;

    // A slot taken by an inserted zero leaves the framer bit pending
    assign consume  = bit_strobe & ~zero_ins;
    assign last_bit = (bit_idx == '1);

    // End of the opening flag or of a payload byte
    assign byte_end = consume & last_bit &
                      ((state == ST_FLAG_OPEN) || (state == ST_PAYLOAD));

    assign load_byte = byte_end & ~fifo_empty;

    assign pop    = load_byte;
    assign tx_drq = load_byte;  // Host may refill one slot

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
            crc_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bit_strobe && !fifo_empty) begin
                        state   <= ST_FLAG_OPEN;
                        bit_idx <= '0;
                    end
                end
                ST_FLAG_OPEN, ST_PAYLOAD: begin
                    if (consume) begin
                        bit_idx <= bit_idx + 1'b1;  // Wraps to 0 at the byte end
                        if (last_bit) begin
                            if (fifo_empty) begin
                                state   <= ST_CRC;      // No more data
                                crc_idx <= '0;
                            end else begin
                                state <= ST_PAYLOAD;
                            end
                        end
                    end
                end
                ST_CRC: begin
                    if (consume) begin
                        crc_idx <= crc_idx + 1'b1;
                        if (crc_idx == '1) begin
                            state   <= ST_FLAG_CLOSE;
                            bit_idx <= '0;
                        end
                    end
                end
                ST_FLAG_CLOSE: begin
                    if (consume) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (last_bit) begin
                            state <= ST_IDLE;   // Frame done
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_byte) begin
            shreg <= rd_data;
        end else if (consume && state == ST_PAYLOAD) begin
            shreg <= shreg >> 1;
        end
    end

    assign crc_din = shreg[0];

    always_comb begin
        tx_bit.value     = 1'b1;
        tx_bit.stuffable = 1'b0;
        tx_bit.present   = 1'b1;
        crc_op           = CRC_HOLD;
        case (state)
            ST_IDLE: begin
                tx_bit.present = 1'b0;
                crc_op         = CRC_INIT;  // Preset ahead of the next frame
            end
            ST_FLAG_OPEN, ST_FLAG_CLOSE: begin
                tx_bit.value = FLAG_BYTE[bit_idx];
            end
            ST_PAYLOAD: begin
                tx_bit.value     = shreg[0];
                tx_bit.stuffable = 1'b1;
                if (consume) begin
                    crc_op = CRC_FEED;
                end
            end
            ST_CRC: begin
                tx_bit.value     = crc_dout;
                tx_bit.stuffable = 1'b1;
                if (consume) begin
                    crc_op = CRC_SHIFT;
                end
            end
            default: begin
                tx_bit.present = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/bit_stuffer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_stuffer (
    input  logic                clk,
    input  logic                tx_crc_rst,
    input  logic                bit_strobe,
    input  sdlc_pkg::line_bit_t tx_bit,
    output logic                zero_ins,
    output logic                tx_data,
    output logic                sdlc_dir
);
    import sdlc_pkg::*;

    // Consecutive stuffable ones already on the line
    logic [$clog2(STUFF_RUN + 1)-1:0] run_cnt;
    logic                             run_full;

    assign run_full = (run_cnt == STUFF_RUN);

    // The run only grows on payload and CRC ones, so a full run ahead of
    // the closing flag still gets its zero before the flag goes out
    assign zero_ins = run_full & tx_bit.present;

    always_ff @(posedge clk) begin
        if (tx_crc_rst) begin
            run_cnt  <= '0;
            tx_data  <= 1'b1;
            sdlc_dir <= 1'b0;
        end else if (bit_strobe) begin
            sdlc_dir <= tx_bit.present;
            if (zero_ins) begin
                tx_data <= 1'b0;            // Inserted zero
                run_cnt <= '0;
            end else if (tx_bit.present) begin
                tx_data <= tx_bit.value;
                if (tx_bit.value && tx_bit.stuffable) begin
                    run_cnt <= run_cnt + 1'b1;
                end else begin
                    run_cnt <= '0;          // Zero or flag bit breaks the run
                end
            end else begin
                tx_data <= 1'b1;            // Line idles at mark
                run_cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdlc_tx.sv
`timescale 1ns/1ps
`default_nettype none

module sdlc_tx (
    input  logic               clk,
    input  logic               tx_crc_rst,
    input  sdlc_pkg::host_wr_t host_wr,
    output logic               tx_clk,
    output logic               tx_data,
    output logic               sdlc_dir,
    output logic               tx_drq
);
    import sdlc_pkg::*;

    logic      bit_strobe;
    byte_t     rd_data;
    logic      fifo_empty;
    logic      pop;
    crc_op_e   crc_op;
    logic      crc_din;
    logic      crc_dout;
    line_bit_t tx_bit;
    logic      zero_ins;

    bit_timer u_bit_timer (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .bit_strobe (bit_strobe),
        .tx_clk     (tx_clk)
    );

    tx_fifo u_tx_fifo (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .host_wr    (host_wr),
        .pop        (pop),
        .rd_data    (rd_data),
        .fifo_empty (fifo_empty)
    );

    crc16_tx u_crc16_tx (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .crc_op     (crc_op),
        .crc_din    (crc_din),
        .crc_dout   (crc_dout)
    );

    tx_framer u_tx_framer (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .bit_strobe (bit_strobe),
        .fifo_empty (fifo_empty),
        .rd_data    (rd_data),
        .zero_ins   (zero_ins),
        .crc_dout   (crc_dout),
        .pop        (pop),
        .tx_drq     (tx_drq),
        .crc_op     (crc_op),
        .crc_din    (crc_din),
        .tx_bit     (tx_bit)
    );

    // Zero insertion and the registered line pins
    bit_stuffer u_bit_stuffer (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .bit_strobe (bit_strobe),
        .tx_bit     (tx_bit),
        .zero_ins   (zero_ins),
        .tx_data    (tx_data),
        .sdlc_dir   (sdlc_dir)
    );

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic tx_crc_rst
);
    localparam int HALF_PERIOD_NS = 10;   // 20 ns clock
    localparam int RST_CYCLES     = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    // Released just after an edge, like the other stimulus
    initial begin
        tx_crc_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        tx_crc_rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/tb_sdlc_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdlc_tx;
    import sdlc_pkg::*;

    localparam int CLK_PERIOD_NS = 20;
    localparam int IDLE_CYCLES   = 200;
    localparam int FRAMES_TOTAL  = 8;      // One each in tests 2 to 4, five in test 5
    localparam int PAYLOAD_MAX   = 16;
    // Flags, worst case stuffing of payload and CRC, plus idle slots around the frame
    localparam int FRAME_BITS_MAX = (PAYLOAD_MAX * 8 + 16) * 6 / 5 + 2 * 8 + 2;
    localparam int TIMEOUT_NS = 2 * (FRAMES_TOTAL * FRAME_BITS_MAX * BIT_PERIOD
                                     + IDLE_CYCLES) * CLK_PERIOD_NS;

    logic     clk;
    logic     tx_crc_rst;
    host_wr_t host_wr;
    logic     tx_clk;
    logic     tx_data;
    logic     sdlc_dir;
    logic     tx_drq;

    logic  raw_bits [$];   // Line bits of the frame in progress
    byte_t rx_bytes [$];   // Destuffed bytes of the last frame
    logic  framing_ok;
    logic  stuff_ok;
    time   clk_rise_t  = 0;
    int    frames_done = 0;
    int    drq_count   = 0;
    int    checks      = 0;
    int    errors      = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst)
    );

    sdlc_tx u_sdlc_tx (
        .clk        (clk),
        .tx_crc_rst (tx_crc_rst),
        .host_wr    (host_wr),
        .tx_clk     (tx_clk),
        .tx_data    (tx_data),
        .sdlc_dir   (sdlc_dir),
        .tx_drq     (tx_drq)
    );

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // X.25 CRC, reflected, computed bit by bit from the polynomial
    function automatic crc_t calc_crc16(input byte_t data[$]);
        crc_t crc;
        logic fb;
        crc = CRC_PRESET;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[i][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    // Strip both flags, drop the zero after each run of five ones, pack LSB first
    task automatic decode_frame();
        byte_t cur;
        int    ones;
        int    nbits;
        int    last;
        cur        = '0;
        ones       = 0;
        nbits      = 0;
        last       = raw_bits.size() - 8;
        framing_ok = 1'b1;
        stuff_ok   = 1'b1;
        rx_bytes.delete();
        if (raw_bits.size() < 16) begin
            framing_ok = 1'b0;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            if (raw_bits[i] !== FLAG_BYTE[i] || raw_bits[last + i] !== FLAG_BYTE[i]) begin
                framing_ok = 1'b0;
            end
        end
        for (int i = 8; i < last; i++) begin
            if (ones == STUFF_RUN) begin
                if (raw_bits[i] !== 1'b0) begin
                    stuff_ok = 1'b0;      // Six ones in a row
                end
                ones = 0;
            end else begin
                ones = (raw_bits[i] === 1'b1) ? ones + 1 : 0;
                cur  = {raw_bits[i], cur[7:1]};
                nbits++;
                if (nbits % 8 == 0) begin
                    rx_bytes.push_back(cur);
                end
            end
        end
        if (nbits % 8 != 0) begin
            framing_ok = 1'b0;
        end
    endtask

    // Line sampled mid-bit, a frame is one stretch of sdlc_dir high
    always @(posedge tx_clk) begin
        if (sdlc_dir === 1'b1) begin
            raw_bits.push_back(tx_data);
        end else if (raw_bits.size() > 0) begin
            decode_frame();
            raw_bits.delete();
            frames_done++;
        end
    end

    // tx_clk runs at the bit rate and rises in the middle of the bit
    always @(posedge tx_clk) begin
        if (clk_rise_t != 0) begin
            check_level($time - clk_rise_t == BIT_PERIOD * CLK_PERIOD_NS, 1'b1,
                        "tx_clk period");
        end
        clk_rise_t = $time;
    end

    always @(negedge tx_clk) begin
        if (clk_rise_t != 0) begin
            check_level($time - clk_rise_t == (BIT_PERIOD - CLK_RISE_PHASE) * CLK_PERIOD_NS,
                        1'b1, "tx_clk high time");
        end
    end

    always @(posedge clk) begin
        if (tx_drq === 1'b1) begin
            drq_count++;
        end
    end

    task automatic write_bytes(input byte_t data[$]);
        foreach (data[i]) begin
            @(posedge clk);
            #1;
            host_wr.strobe = 1'b1;
            host_wr.data   = data[i];
        end
        @(posedge clk);
        #1;
        host_wr = '0;
    endtask

    task automatic send_and_check(input byte_t data[$], input string name);
        crc_t crc;
        int   drq_base;
        int   target;
        int   n;
        crc      = calc_crc16(data);
        drq_base = drq_count;
        target   = frames_done + 1;
        n        = data.size();
        write_bytes(data);
        wait (frames_done >= target);
        check_level(framing_ok, 1'b1, $sformatf("%s: flags and byte alignment", name));
        check_level(stuff_ok, 1'b1, $sformatf("%s: zero after five ones", name));
        check_level(rx_bytes.size() == n + 2, 1'b1,
                    $sformatf("%s: %0d bytes between flags", name, rx_bytes.size()));
        if (rx_bytes.size() == n + 2) begin
            foreach (data[i]) begin
                check_byte(rx_bytes[i], data[i], $sformatf("%s: payload byte %0d", name, i));
            end
            check_byte(rx_bytes[n], crc[7:0], $sformatf("%s: CRC low byte", name));
            check_byte(rx_bytes[n + 1], crc[15:8], $sformatf("%s: CRC high byte", name));
        end
        check_level(drq_count - drq_base == n, 1'b1,
                    $sformatf("%s: %0d tx_drq pulses", name, drq_count - drq_base));
        check_level(tx_data, 1'b1, $sformatf("%s: line at mark after frame", name));
    endtask

    task automatic idle_after_reset();
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            #1;
            check_level(sdlc_dir, 1'b0, "idle sdlc_dir");
            check_level(tx_drq, 1'b0, "idle tx_drq");
            check_level(tx_data, 1'b1, "idle tx_data");
        end
    endtask

    task automatic single_byte_frame();
        byte_t data[$];
        data.push_back(byte_t'($urandom));
        send_and_check(data, "single byte");
    endtask

    task automatic known_crc_frame();
        byte_t data[$];
        data = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
        send_and_check(data, "known CRC");
        if (rx_bytes.size() == 11) begin
            check_byte(rx_bytes[9], 8'h6E, "known CRC low byte");
            check_byte(rx_bytes[10], 8'h90, "known CRC high byte");
        end
    endtask

    task automatic zero_insertion_frame();
        byte_t data[$];
        data = '{8'hFF, 8'hFF, 8'h7E, 8'h3F};   // Long runs of ones, one flag lookalike
        send_and_check(data, "zero insertion");
    endtask

    task automatic random_frames();
        byte_t data[$];
        int    len;
        for (int f = 0; f < 5; f++) begin
            data.delete();
            len = $urandom_range(PAYLOAD_MAX, 1);
            repeat (len) begin
                data.push_back(byte_t'($urandom));
            end
            send_and_check(data, $sformatf("random frame %0d", f));
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Simulation timed out after %0d ns with %0d frames seen", TIMEOUT_NS,
                 frames_done);
        $display("Verification failed");
        $finish;
    end

    initial begin
        host_wr = '0;
        void'($urandom(32'h34cb_815a));
        wait (tx_crc_rst === 1'b0);
        idle_after_reset();
        single_byte_frame();
        known_crc_frame();
        zero_insertion_frame();
        random_frames();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sdlc_tx.f
rtl/sdlc_pkg.sv
rtl/bit_timer.sv
rtl/tx_fifo.sv
rtl/crc16_tx.sv
rtl/tx_framer.sv
rtl/bit_stuffer.sv
rtl/sdlc_tx.sv
bench/tb_clk_gen.sv
bench/tb_sdlc_tx.sv

// File: Bender.yml
package:
  name: sdlc_tx

sources:
  - rtl/sdlc_pkg.sv
  - rtl/bit_timer.sv
  - rtl/tx_fifo.sv
  - rtl/crc16_tx.sv
  - rtl/tx_framer.sv
  - rtl/bit_stuffer.sv
  - rtl/sdlc_tx.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_sdlc_tx.sv
